// File: Makefile
TOOL       := verilator
TOP        := cpuTb
FILELIST   := all.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)
SIM_FLAGS  := --binary --timing --top-module $(TOP) --Mdir $(BUILD_DIR)
PASS_MSG   := PASS: all tests

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: all.f
verilog/cpuPkg.sv
verilog/alu.sv
verilog/regFile.sv
verilog/wordMemory.sv
verilog/hazardUnit.sv
verilog/decodeStage.sv
verilog/cpu.sv
dv/clockGen.sv
dv/cpuTb.sv

// File: dv/clockGen.sv
`timescale 1ns/1ps

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		@(negedge clk); // release away from the active edge
		reset = 1'b0;
	end

endmodule

// File: dv/cpuTb.sv
`timescale 1ns/1ps

module cpuTb;
	import cpuPkg::*;

	localparam int numProgs = 20;
	localparam int progLen = 48; // random part, HLT follows
	localparam int runLimit = 3000; // cycles allowed to reach hlt
	localparam int bootIdle = 5; // cycles parked in boot before run
	localparam int postHalt = 12;

	logic clk;
	logic genReset;
	logic loadReset; // per-program reset, ORed with power-on
	logic run;
	logic progWrite;
	word_t progAddr;
	word_t progData;
	logic hlt;
	logic wbValid;
	word_t pc;
	word_t wbData;
	regId_t wbReg;

	integer seed;
	word_t prog [progLen + 1];
	regId_t expReg [$]; // model trace, in commit order
	word_t expData [$];

	clockGen u_clockGen (.clk(clk), .reset(genReset));

	cpu #(.IMEM_WORDS(256), .DMEM_WORDS(256)) u_cpu (
		.clk(clk), .reset(genReset || loadReset), .run(run),
		.progWrite(progWrite), .progAddr(progAddr), .progData(progData),
		.hlt(hlt), .pc(pc), .wbValid(wbValid), .wbReg(wbReg), .wbData(wbData));

	task automatic abortRun();
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic checkBit(string name, logic expected, logic actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %b got %b", $time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkReg(string name, regId_t expected, regId_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected r%0d got r%0d", $time, name, expected, actual);
			abortRun();
		end
	endtask

	task automatic checkWord(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
			abortRun();
		end
	endtask

	function automatic int pick(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// weighted toward byte loads and arithmetic so values get large
	function automatic opcode_t pickOpcode();
		case (pick(16))
			0, 1: return opAdd;
			2, 3: return opSub;
			4: return opXor;
			5: return opSll;
			6: return opSra;
			7: return opRor;
			8: return opLw;
			9: return opSw;
			10: return opLlb;
			11, 12: return opLhb;
			13, 14: return opB;
			default: return opcode_t'(4'hD); // unused opcode
		endcase
	endfunction

	function automatic word_t randomInstr(int idx);
		opcode_t op;
		int room;
		word_t ins;
		op = pickOpcode();
		room = progLen - 1 - idx; // target may be the HLT, never past it
		if (room > 5)
			room = 5;
		ins[15:12] = op;
		ins[11:8] = regId_t'(pick(8)); // small reg set, lots of dependencies
		ins[7:4] = regId_t'(pick(8));
		ins[3:0] = regId_t'(pick(16)); // shift amount or mem offset
		if (op == opLlb || op == opLhb)
			ins[7:0] = 8'(pick(256));
		else if (op == opB)
			ins[11:0] = {3'(pick(8)), 9'(pick(room + 1))}; // forward only
		else if (op inside {opAdd, opSub, opXor})
			ins[3:0] = regId_t'(pick(8));
		return ins;
	endfunction

	task automatic makeProgram();
		for (int i = 0; i < progLen; i++)
			prog[i] = randomInstr(i);
		prog[progLen] = {opHlt, 12'h000};
	endtask

	// clamp a 17-bit signed sum into 16 bits
	function automatic word_t saturate(logic signed [16:0] wide, output logic ovf);
		ovf = (wide > 17'sd32767) || (wide < -17'sd32768);
		if (wide > 17'sd32767)
			return 16'h7FFF;
		if (wide < -17'sd32768)
			return 16'h8000;
		return wide[15:0];
	endfunction

	function automatic logic condHolds(logic [2:0] cc, flags_t f);
		case (cc)
			3'd0: return !f.z; // ne
			3'd1: return f.z;
			3'd2: return !f.z && !f.n; // gt
			3'd3: return f.n;
			3'd4: return f.z || !f.n; // ge
			3'd5: return f.z || f.n;
			3'd6: return f.v;
			default: return 1'b1;
		endcase
	endfunction

	// sequential ISA interpreter, fills the expected trace
	task automatic runModel();
		word_t regs [16];
		word_t dmem [256];
		flags_t fl;
		int idx;
		word_t ins, a, b, res, addr;
		opcode_t op;
		regId_t rd;
		logic ovf;
		logic writes;
		expReg.delete();
		expData.delete();
		for (int i = 0; i < 16; i++)
			regs[i] = '0;
		for (int i = 0; i < 256; i++)
			dmem[i] = '0; // data memory cleared by reset
		fl = '0;
		idx = 0;
		while (idx <= progLen && prog[idx][15:12] != opHlt) begin
			ins = prog[idx];
			op = ins[15:12];
			rd = ins[11:8];
			a = regs[ins[7:4]];
			b = regs[ins[3:0]];
			addr = a + {{11{ins[3]}}, ins[3:0], 1'b0}; // byte address, wraps
			res = '0;
			writes = 1'b1;
			idx++;
			case (op)
				opAdd: res = saturate($signed({a[15], a}) + $signed({b[15], b}), ovf);
				opSub: res = saturate($signed({a[15], a}) - $signed({b[15], b}), ovf);
				opXor: res = a ^ b;
				opSll: res = a << ins[3:0];
				opSra: res = word_t'($signed(a) >>> ins[3:0]);
				opRor: res = (a >> ins[3:0]) | (a << (16 - ins[3:0]));
				opLw: res = dmem[addr[8:1]]; // 256 words, index wraps
				opSw: begin
					dmem[addr[8:1]] = regs[rd];
					writes = 1'b0;
				end
				opLlb: res = {regs[rd][15:8], ins[7:0]};
				opLhb: res = {ins[7:0], regs[rd][7:0]};
				opB: begin
					writes = 1'b0;
					if (condHolds(ins[11:9], fl))
						idx += int'($signed(ins[8:0]));
				end
				default: writes = 1'b0; // unused opcodes
			endcase
			if (op == opAdd || op == opSub) begin
				fl.z = (res == '0);
				fl.v = ovf;
				fl.n = res[15];
			end else if (op inside {opXor, opSll, opSra, opRor}) begin
				fl.z = (res == '0); // v and n kept
			end
			if (writes && rd != '0) begin
				regs[rd] = res;
				expReg.push_back(rd);
				expData.push_back(res);
			end
		end
	endtask

	task automatic loadProgram();
		@(negedge clk);
		run = 1'b0;
		loadReset = 1'b1;
		for (int i = 0; i <= progLen; i++) begin
			progWrite = 1'b1;
			progAddr = word_t'(i);
			progData = prog[i];
			@(negedge clk);
		end
		progWrite = 1'b0;
		loadReset = 1'b0;
	endtask

	// core idles in boot, nothing may commit
	task automatic checkBoot();
		repeat (bootIdle) begin
			@(negedge clk);
			checkBit("hlt", 1'b0, hlt);
			checkBit("wbValid", 1'b0, wbValid);
			checkWord("pc", '0, pc); // boot holds fetch at 0
		end
		run = 1'b1;
	endtask

	task automatic runAndCheck(int progNum);
		int cycles;
		int got;
		word_t haltPc;
		cycles = 0;
		got = 0;
		while (!hlt) begin
			@(negedge clk);
			cycles++;
			if (cycles > runLimit) begin
				$display("program %0d: hlt did not rise within %0d cycles", progNum, runLimit);
				abortRun();
			end
			if (wbValid) begin
				if (got >= expReg.size()) begin
					$display("program %0d: write to r%0d beyond the %0d expected writes",
						progNum, wbReg, expReg.size());
					abortRun();
				end
				checkReg("wbReg", expReg[got], wbReg);
				checkWord("wbData", expData[got], wbData);
				got++;
			end
		end
		haltPc = word_t'(2 * progLen); // byte address of the HLT, fetch parks there
		repeat (postHalt) begin // halted core must stay frozen
			@(negedge clk);
			checkBit("hlt", 1'b1, hlt);
			checkBit("wbValid", 1'b0, wbValid);
			checkWord("pc", haltPc, pc);
		end
		if (got != expReg.size()) begin
			$display("program %0d: trace held %0d writes but the model expects %0d",
				progNum, got, expReg.size());
			abortRun();
		end
		$display("program %0d: %0d writes matched in %0d cycles", progNum, got, cycles);
	endtask

	initial begin
		seed = 32'h6903;
		loadReset = 1'b1;
		run = 1'b0;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		for (int p = 0; p < numProgs; p++) begin
			makeProgram();
			runModel();
			loadProgram();
			checkBoot();
			runAndCheck(p);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
	input cpuPkg::aluOp_t opcode,
	input cpuPkg::word_t a,
	input cpuPkg::word_t b,
	output cpuPkg::word_t result,
	output cpuPkg::flags_t flags
);
	import cpuPkg::*;

	word_t sum;
	word_t diff;
	word_t satValue;
	logic sumOvf;
	logic diffOvf;
	logic [3:0] shamt;
	logic [31:0] rotWide;

	assign shamt = b[3:0]; // shifts only look at low nibble
	assign sum = a + b;
	assign diff = a - b;
	// signed overflow, same sign in and different sign out
	assign sumOvf = (a[15] == b[15]) && (sum[15] != a[15]);
	assign diffOvf = (a[15] != b[15]) && (diff[15] != a[15]);
	// overflow always goes the way of a's sign
	assign satValue = a[15] ? 16'h8000 : 16'h7FFF;
	assign rotWide = {a, a} >> shamt; // rotate via doubled word

	always_comb begin
		case (opcode)
			aluAdd: result = sumOvf ? satValue : sum;
			aluSub: result = diffOvf ? satValue : diff;
			aluXor: result = a ^ b;
			aluSll: result = a << shamt;
			aluSra: result = $signed(a) >>> shamt;
			aluRor: result = rotWide[15:0];
			aluLlb: result = {a[15:8], b[7:0]}; // keep high byte
			aluLhb: result = {b[7:0], a[7:0]}; // keep low byte
			default: result = b; // pass, used by mem ops and no-ops
		endcase
	end

	always_comb begin
		flags.z = (result == '0);
		flags.n = result[15]; // meaningful for add/sub only
		case (opcode)
			aluAdd: flags.v = sumOvf;
			aluSub: flags.v = diffOvf;
			default: flags.v = 1'b0;
		endcase
	end

endmodule

// File: verilog/cpu.sv
`timescale 1ns/1ps

module cpu #(
	parameter int IMEM_WORDS = 256,
	parameter int DMEM_WORDS = 256
) (
	input logic clk,
	input logic reset,
	input logic run,
	input logic progWrite,
	input cpuPkg::word_t progAddr,
	input cpuPkg::word_t progData,
	output logic hlt,
	output cpuPkg::word_t pc,
	output logic wbValid,
	output cpuPkg::regId_t wbReg,
	output cpuPkg::word_t wbData
);
	import cpuPkg::*;

	typedef enum logic [1:0] {sBoot, sRun, sHalt} state_t;

	localparam word_t bubbleInstr = 16'h3000; // opcode 3 decodes as no-op

	state_t state;
	word_t pcReg, pcPlus2, imemAddr, imemData;
	word_t ifIdInstr, ifIdPcPlus2;
	idEx_t idEx, idExNext;
	exMem_t exMem;
	memWb_t memWb;
	flags_t flagReg, aluFlags;
	regId_t readB;
	word_t regA, regB, branchTarget;
	logic fetchActive, stall, flushIf, storeFwd, branchTaken;
	fwdSel_t fwdA, fwdB;
	word_t fwdValA, fwdValB, aluB, aluResult, memAddr;
	word_t dmemData, storeData, memStageData;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= sBoot;
		end else begin
			case (state)
				sBoot: if (run) state <= sRun;
				sRun: if (memWb.halt) state <= sHalt; // HLT committed
				default: state <= sHalt; // only reset leaves
			endcase
		end
	end

	// fetch already runs on the edge that first sees run
	assign fetchActive = (state == sRun) || (state == sBoot && run);
	assign pcPlus2 = pcReg + 16'd2;
	assign imemAddr = progWrite ? progAddr : {1'b0, pcReg[15:1]}; // loader owns the port
	assign flushIf = branchTaken && !stall;

	wordMemory #(.DEPTH(IMEM_WORDS), .CLEAR_ON_RESET(1'b0)) u_imem (
		.clk, .reset, .writeEn(progWrite), .addr(imemAddr),
		.writeData(progData), .readData(imemData));

	always_ff @(posedge clk) begin
		if (reset) begin
			pcReg <= '0;
		end else if (fetchActive && !stall) begin
			if (flushIf)
				pcReg <= branchTarget;
			else if (imemData[15:12] != opHlt) // park on a fetched HLT
				pcReg <= pcPlus2;
		end
	end

	always_ff @(posedge clk) begin
		if (reset || !fetchActive || flushIf) begin
			ifIdInstr <= bubbleInstr;
			ifIdPcPlus2 <= '0;
		end else if (!stall) begin
			ifIdInstr <= imemData;
			ifIdPcPlus2 <= pcPlus2;
		end
	end

	regFile u_regFile (
		.clk, .reset, .readA(ifIdInstr[7:4]), .readB(readB),
		.writeEn(memWb.regWrite), .writeReg(memWb.rd), .writeData(memWb.writeData),
		.dataA(regA), .dataB(regB));

	decodeStage u_decode (
		.instr(ifIdInstr), .pcPlus2(ifIdPcPlus2), .flags(flagReg),
		.dataA(regA), .dataB(regB), .readB(readB), .ctrl(idExNext),
		.branchTaken(branchTaken), .branchTarget(branchTarget));

	hazardUnit u_hazard (
		.ifId(ifIdInstr), .idEx, .exMem, .memWb,
		.stall, .fwdA, .fwdB, .storeFwd);

	always_ff @(posedge clk) begin
		if (reset || stall)
			idEx <= '0; // bubble
		else
			idEx <= idExNext;
	end

	// EX operand muxes
	assign fwdValA = (fwdA == fwdMem) ? memStageData :
		(fwdA == fwdWb) ? memWb.writeData : idEx.operandA;
	assign fwdValB = (fwdB == fwdMem) ? memStageData :
		(fwdB == fwdWb) ? memWb.writeData : idEx.operandB;
	assign aluB = idEx.useImm ? idEx.imm : fwdValB;
	assign memAddr = fwdValA + idEx.imm; // wrapping add, not the saturating one

	alu u_alu (.opcode(idEx.aluOp), .a(fwdValA), .b(aluB), .result(aluResult),
		.flags(aluFlags));

	always_ff @(posedge clk) begin
		if (reset)
			flagReg <= '0;
		else
			flagReg <= (flagReg & ~idEx.flagWrite) | (aluFlags & idEx.flagWrite);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			exMem <= '0;
		end else begin
			exMem.result <= (idEx.memRead || idEx.memWrite) ? memAddr : aluResult;
			exMem.storeData <= fwdValB;
			exMem.rd <= idEx.rd;
			exMem.regWrite <= idEx.regWrite;
			exMem.memRead <= idEx.memRead;
			exMem.memWrite <= idEx.memWrite;
			exMem.halt <= idEx.halt;
		end
	end

	assign storeData = storeFwd ? memWb.writeData : exMem.storeData;

	wordMemory #(.DEPTH(DMEM_WORDS), .CLEAR_ON_RESET(1'b1)) u_dmem (
		.clk, .reset, .writeEn(exMem.memWrite), .addr({1'b0, exMem.result[15:1]}),
		.writeData(storeData), .readData(dmemData));

	// load data or alu result, also the mem-stage forward value
	assign memStageData = exMem.memRead ? dmemData : exMem.result;

	always_ff @(posedge clk) begin
		if (reset) begin
			memWb <= '0;
		end else begin
			memWb.writeData <= memStageData;
			memWb.rd <= exMem.rd;
			memWb.regWrite <= exMem.regWrite;
			memWb.halt <= exMem.halt;
		end
	end

	assign wbValid = memWb.regWrite;
	assign wbReg = memWb.rd;
	assign wbData = memWb.writeData;
	assign hlt = (state == sHalt);
	assign pc = pcReg;

endmodule

// File: verilog/cpuPkg.sv
package cpuPkg;

	typedef logic [15:0] word_t; // data word, also byte address
	typedef logic [3:0] regId_t;
	typedef logic [3:0] opcode_t; // instr[15:12]

	localparam opcode_t opAdd = 4'h0; // saturating
	localparam opcode_t opSub = 4'h1; // saturating
	localparam opcode_t opXor = 4'h2;
	localparam opcode_t opSll = 4'h4;
	localparam opcode_t opSra = 4'h5;
	localparam opcode_t opRor = 4'h6;
	localparam opcode_t opLw = 4'h8;
	localparam opcode_t opSw = 4'h9;
	localparam opcode_t opLlb = 4'hA;
	localparam opcode_t opLhb = 4'hB;
	localparam opcode_t opB = 4'hC; // conditional branch
	localparam opcode_t opHlt = 4'hF;

	typedef struct packed {
		logic z;
		logic v;
		logic n;
	} flags_t;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluXor, aluSll, aluSra, aluRor, aluLlb, aluLhb, aluPass
	} aluOp_t;

	// where an EX operand comes from
	typedef enum logic [1:0] {fwdNone, fwdMem, fwdWb} fwdSel_t;

	typedef struct packed {
		aluOp_t aluOp;
		word_t operandA;
		word_t operandB;
		word_t imm;
		regId_t rs; // id behind operandA
		regId_t rt; // id behind operandB
		regId_t rd;
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic useImm;
		logic [2:0] flagWrite; // z v n enables
		logic halt;
	} idEx_t;

	typedef struct packed {
		word_t result; // alu result or byte address
		word_t storeData;
		regId_t rd; // store data reg for SW
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic halt;
	} exMem_t;

	typedef struct packed {
		word_t writeData;
		regId_t rd;
		logic regWrite;
		logic halt;
	} memWb_t;

endpackage

// File: verilog/decodeStage.sv
`timescale 1ns/1ps

module decodeStage (
	input cpuPkg::word_t instr,
	input cpuPkg::word_t pcPlus2,
	input cpuPkg::flags_t flags,
	input cpuPkg::word_t dataA,
	input cpuPkg::word_t dataB,
	output cpuPkg::regId_t readB,
	output cpuPkg::idEx_t ctrl,
	output logic branchTaken,
	output cpuPkg::word_t branchTarget
);
	import cpuPkg::*;

	opcode_t op;
	regId_t rd;
	logic byteLoad;
	logic condMet;

	assign op = instr[15:12];
	assign rd = instr[11:8];
	assign byteLoad = (op == opLlb) || (op == opLhb); // read-modify-write of rd
	assign readB = (op == opSw || byteLoad) ? rd : instr[3:0];

	// 9-bit signed offset in halfwords
	assign branchTarget = pcPlus2 + {{6{instr[8]}}, instr[8:0], 1'b0};

	always_comb begin
		case (instr[11:9])
			3'b000: condMet = !flags.z; // ne
			3'b001: condMet = flags.z; // eq
			3'b010: condMet = !flags.z && !flags.n; // gt
			3'b011: condMet = flags.n; // lt
			3'b100: condMet = flags.z || !flags.n; // ge
			3'b101: condMet = flags.n || flags.z; // le
			3'b110: condMet = flags.v;
			default: condMet = 1'b1; // unconditional
		endcase
	end
	assign branchTaken = (op == opB) && condMet;

	always_comb begin
		ctrl = '0;
		case (op)
			opAdd: ctrl.aluOp = aluAdd;
			opSub: ctrl.aluOp = aluSub;
			opXor: ctrl.aluOp = aluXor;
			opSll: ctrl.aluOp = aluSll;
			opSra: ctrl.aluOp = aluSra;
			opRor: ctrl.aluOp = aluRor;
			opLlb: ctrl.aluOp = aluLlb;
			opLhb: ctrl.aluOp = aluLhb;
			default: ctrl.aluOp = aluPass; // mem ops, branch, no-ops
		endcase
		// byte loads take rd's old value as operand A
		ctrl.rs = byteLoad ? rd : instr[7:4];
		ctrl.operandA = byteLoad ? dataB : dataA;
		ctrl.rt = readB;
		ctrl.operandB = dataB;
		ctrl.rd = rd;
		if (op == opLw || op == opSw)
			ctrl.imm = {{11{instr[3]}}, instr[3:0], 1'b0}; // word aligned offset
		else if (byteLoad)
			ctrl.imm = {8'h00, instr[7:0]};
		else
			ctrl.imm = {12'h000, instr[3:0]}; // shift amount
		ctrl.useImm = op inside {opSll, opSra, opRor, opLlb, opLhb};
		ctrl.regWrite = (rd != '0) &&
			(op inside {opAdd, opSub, opXor, opSll, opSra, opRor, opLw, opLlb, opLhb});
		ctrl.memRead = (op == opLw);
		ctrl.memWrite = (op == opSw);
		if (op == opAdd || op == opSub)
			ctrl.flagWrite = 3'b111;
		else if (op inside {opXor, opSll, opSra, opRor})
			ctrl.flagWrite = 3'b100; // z only
		ctrl.halt = (op == opHlt);
	end

endmodule

// File: verilog/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input cpuPkg::word_t ifId,
	input cpuPkg::idEx_t idEx,
	input cpuPkg::exMem_t exMem,
	input cpuPkg::memWb_t memWb,
	output logic stall,
	output cpuPkg::fwdSel_t fwdA,
	output cpuPkg::fwdSel_t fwdB,
	output logic storeFwd
);
	import cpuPkg::*;

	opcode_t op;
	logic usesRs;
	logic usesRt;
	logic usesRd;
	logic loadUse;
	logic flagWait;

	// nearest producer first, mem stage beats writeback
	function automatic fwdSel_t pickSource(regId_t src, exMem_t mem, memWb_t wb);
		if (mem.regWrite && mem.rd != '0 && mem.rd == src)
			return fwdMem;
		if (wb.regWrite && wb.rd != '0 && wb.rd == src)
			return fwdWb;
		return fwdNone;
	endfunction

	assign op = ifId[15:12];
	assign usesRs = op inside {opAdd, opSub, opXor, opSll, opSra, opRor, opLw, opSw};
	assign usesRt = op inside {opAdd, opSub, opXor};
	// SW data left out, load result reaches it by forwarding in EX
	assign usesRd = op inside {opLlb, opLhb};

	assign loadUse = idEx.memRead && idEx.rd != '0 &&
		((usesRs && idEx.rd == ifId[7:4]) ||
		(usesRt && idEx.rd == ifId[3:0]) ||
		(usesRd && idEx.rd == ifId[11:8]));
	assign flagWait = (op == opB) && (idEx.flagWrite != 3'b000); // flags land end of EX
	assign stall = loadUse || flagWait;

	assign fwdA = pickSource(idEx.rs, exMem, memWb);
	assign fwdB = pickSource(idEx.rt, exMem, memWb);
	// late catch for store data, overrides in MEM
	assign storeFwd = exMem.memWrite && memWb.regWrite && memWb.rd != '0 &&
		memWb.rd == exMem.rd;

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps

module regFile (
	input logic clk,
	input logic reset,
	input cpuPkg::regId_t readA,
	input cpuPkg::regId_t readB,
	input logic writeEn,
	input cpuPkg::regId_t writeReg,
	input cpuPkg::word_t writeData,
	output cpuPkg::word_t dataA,
	output cpuPkg::word_t dataB
);
	import cpuPkg::*;

	word_t regs [16];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (writeEn && writeReg != '0) begin // r0 never stored
			regs[writeReg] <= writeData;
		end
	end

	// r0 reads zero, then same-cycle write wins over array
	assign dataA = (readA == '0) ? '0 :
		(writeEn && writeReg == readA) ? writeData : regs[readA];
	assign dataB = (readB == '0) ? '0 :
		(writeEn && writeReg == readB) ? writeData : regs[readB];

endmodule

// File: verilog/wordMemory.sv
`timescale 1ns/1ps

module wordMemory #(
	parameter int DEPTH = 256,
	parameter bit CLEAR_ON_RESET = 1'b0
) (
	input logic clk,
	input logic reset,
	input logic writeEn,
	input cpuPkg::word_t addr, // word index
	input cpuPkg::word_t writeData,
	output cpuPkg::word_t readData
);
	import cpuPkg::*;

	localparam int IDX_W = $clog2(DEPTH);

	word_t mem [DEPTH];
	logic [IDX_W-1:0] idx;

	assign idx = IDX_W'(addr % DEPTH); // wraps past the top

	always_ff @(posedge clk) begin
		if (CLEAR_ON_RESET && reset) begin // data side starts zeroed
			for (int i = 0; i < DEPTH; i++)
				mem[i] <= '0;
		end else if (writeEn) begin
			mem[idx] <= writeData;
		end
	end

	assign readData = mem[idx]; // async read

endmodule
